//--- sim.f
rtl/nird_pkg.sv
rtl/pixel_counter.sv
rtl/frame_fsm.sv
rtl/window_buffer.sv
rtl/texture_bits.sv
rtl/riu2_mapping.sv
rtl/nird_top.sv
bench/tb_nird.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_nird
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

# the model's own exit status is not enough, the pass line must be in the output
sim:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/nird_vectors.txt
# 12 rows of 12 pixels in raster order, decimal
# then 64 windows in raster order of their centres, each an ni rd pair, eight pairs per line
0 100 0 100 50 50 50 200 10 200 10 200
4 104 4 104 54 54 54 204 14 204 14 204
8 108 8 108 58 58 58 208 18 208 18 208
12 112 12 112 62 62 62 212 22 212 22 212
16 116 16 116 66 66 66 216 26 216 26 216
20 120 20 120 70 70 70 220 30 220 30 220
24 124 24 124 74 74 74 224 34 224 34 224
28 128 28 128 78 78 78 228 38 228 38 228
32 132 32 132 82 82 82 232 42 232 42 232
36 136 36 136 86 86 86 236 46 236 46 236
40 140 40 140 90 90 90 240 50 240 50 240
44 144 44 144 94 94 94 244 54 244 54 244
2 1 5 6 3 3 9 7 0 3 5 6 0 1 8 7
2 1 5 6 3 3 9 7 0 3 5 6 0 1 8 7
2 1 5 6 3 3 9 7 0 3 5 6 0 1 8 7
2 1 5 6 3 3 9 7 0 3 5 6 0 1 8 7
2 1 5 6 3 3 9 7 0 3 5 6 0 1 8 7
2 1 5 6 3 3 9 7 0 3 5 6 0 1 8 7
2 1 5 6 3 3 9 7 0 3 5 6 0 1 8 7
2 1 5 6 3 3 9 7 0 3 5 6 0 1 8 7

//--- bench/tb_nird.sv
module tb_nird import nird_pkg::*; ();

    localparam int COLS    = 12;
    localparam int ROWS    = 12;
    localparam int NPIX    = COLS * ROWS;
    localparam int NWIN    = (COLS - 4) * (ROWS - 4);
    localparam int LATENCY = 3;
    localparam int TIMEOUT = 50;

    logic  clk_i;
    logic  rst_n_i;
    logic  pix_valid_i;
    pix_t  pix_i;
    code_t ni_o;
    code_t rd_o;
    logic  code_valid_o;
    logic  frame_done_o;

    int     pixels [NPIX];
    int     exp_ni [NWIN];
    int     exp_rd [NWIN];
    int     got_ni [$];
    int     got_rd [$];
    int     got_cyc [$];
    int     got_done [$];
    int     strobe_cyc [$];
    int     cyc;
    integer seed;

    nird_top #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) nird_top_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pix_valid_i  (pix_valid_i),
        .pix_i        (pix_i),
        .ni_o         (ni_o),
        .rd_o         (rd_o),
        .code_valid_o (code_valid_o),
        .frame_done_o (frame_done_o)
    );

    always #50 clk_i = ~clk_i;

    // edge count, read before the update it gives the index of the previous edge
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("[ERROR] %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    // output pairs with the edge that loaded the output register
    always @(posedge clk_i) begin
        if (code_valid_o) begin
            got_ni.push_back(int'(ni_o));
            got_rd.push_back(int'(rd_o));
            got_cyc.push_back(cyc);
            got_done.push_back(int'(frame_done_o));
        end else begin
            check_value(int'(frame_done_o), 0, "frame_done_o high without code_valid_o");
        end
    end

    task automatic read_vectors();
        int    fd;
        int    n;
        int    val;
        int    ni;
        int    rd;
        string hdr;
        fd = $fopen("bench/nird_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open bench/nird_vectors.txt");
        end
        // two header lines describe the columns
        n = $fgets(hdr, fd);
        n = $fgets(hdr, fd);
        for (int i = 0; i < NPIX; i++) begin
            n = $fscanf(fd, "%d", val);
            if (n != 1) begin
                abort_run("vectors file ended before all pixels were read");
            end
            pixels[i] = val;
        end
        for (int j = 0; j < NWIN; j++) begin
            n = $fscanf(fd, "%d %d", ni, rd);
            if (n != 2) begin
                abort_run("vectors file ended before all expected code pairs were read");
            end
            exp_ni[j] = ni;
            exp_rd[j] = rd;
        end
        $fclose(fd);
    endtask

    task automatic send_frame(input int gap_max, input bit uniform);
        int gap;
        for (int i = 0; i < NPIX; i++) begin
            gap = 0;
            if (gap_max > 0) begin
                gap = int'($unsigned($random(seed)) % (gap_max + 1));
            end
            repeat (gap) begin
                @(posedge clk_i);
                pix_valid_i <= 1'b0;
            end
            @(posedge clk_i);
            pix_valid_i <= 1'b1;
            pix_i       <= uniform ? pix_t'(100) : pix_t'(pixels[i]);
            // window completes once four rows and four columns precede it
            if ((i % COLS) >= 4 && (i / COLS) >= 4) begin
                strobe_cyc.push_back(cyc + 1);
            end
        end
        @(posedge clk_i);
        pix_valid_i <= 1'b0;
    endtask

    task automatic wait_codes(input int count);
        int waited;
        waited = 0;
        while (got_ni.size() < count) begin
            @(posedge clk_i);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("timeout while waiting for code pairs from the DUT");
            end
        end
        // room for any extra pair to show up
        for (int k = 0; k < LATENCY + 4; k++) begin
            @(posedge clk_i);
        end
    endtask

    task automatic check_frame(input bit uniform, input string tag);
        int exp_n;
        int exp_r;
        check_value(got_ni.size(), NWIN, {tag, ": number of code pairs"});
        for (int j = 0; j < NWIN; j++) begin
            exp_n = uniform ? 8 : exp_ni[j];
            exp_r = uniform ? 8 : exp_rd[j];
            check_value(got_ni[j], exp_n, $sformatf("%s window %0d ni_o", tag, j));
            check_value(got_rd[j], exp_r, $sformatf("%s window %0d rd_o", tag, j));
            check_value(got_cyc[j] - strobe_cyc[j], LATENCY,
                        $sformatf("%s window %0d latency", tag, j));
            check_value(got_done[j], (j == NWIN - 1) ? 1 : 0,
                        $sformatf("%s window %0d frame_done_o", tag, j));
        end
        got_ni.delete();
        got_rd.delete();
        got_cyc.delete();
        got_done.delete();
        strobe_cyc.delete();
    endtask

    initial begin
        seed        = 32'h379;
        cyc         = 0;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        pix_valid_i = 1'b0;
        pix_i       = '0;
        read_vectors();

        for (int k = 0; k < 4; k++) begin
            @(posedge clk_i);
            check_value(int'(code_valid_o), 0, "code_valid_o during reset");
            check_value(int'(frame_done_o), 0, "frame_done_o during reset");
        end
        rst_n_i <= 1'b1;
        for (int k = 0; k < 5; k++) begin
            @(posedge clk_i);
            check_value(int'(code_valid_o), 0, "code_valid_o before any pixel");
            check_value(int'(frame_done_o), 0, "frame_done_o before any pixel");
        end

        send_frame(0, 1'b0);
        wait_codes(NWIN);
        check_frame(1'b0, "back-to-back frame");

        send_frame(3, 1'b0);
        wait_codes(NWIN);
        check_frame(1'b0, "frame with idle gaps");

        send_frame(0, 1'b1);
        wait_codes(NWIN);
        check_frame(1'b1, "uniform frame");

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- rtl/nird_top.sv
module nird_top import nird_pkg::*; #(
    parameter int COLS = 12,
    parameter int ROWS = 12
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  pix_valid_i,
    input  pix_t  pix_i,
    output code_t ni_o,
    output code_t rd_o,
    output logic  code_valid_o,
    output logic  frame_done_o
);

    pos_t          col;
    pos_t          row;
    stage_ctl_t    win_ctl;
    window_t       win;
    pattern_pair_t pat;
    stage_ctl_t    pat_ctl;

    pixel_counter #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) pixel_counter_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .pix_valid_i (pix_valid_i),
        .col_o       (col),
        .row_o       (row)
    );

    frame_fsm #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) frame_fsm_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .pix_valid_i (pix_valid_i),
        .col_i       (col),
        .row_i       (row),
        .ctl_o       (win_ctl)
    );

    // registers on the same strobe as frame_fsm, so win and win_ctl line up
    window_buffer #(
        .COLS (COLS)
    ) window_buffer_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .pix_valid_i (pix_valid_i),
        .pix_i       (pix_i),
        .win_o       (win)
    );

    texture_bits texture_bits_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .win_i   (win),
        .ctl_i   (win_ctl),
        .pat_o   (pat),
        .ctl_o   (pat_ctl)
    );

    riu2_mapping riu2_mapping_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pat_i        (pat),
        .ctl_i        (pat_ctl),
        .ni_o         (ni_o),
        .rd_o         (rd_o),
        .code_valid_o (code_valid_o),
        .frame_done_o (frame_done_o)
    );

endmodule

//--- rtl/riu2_mapping.sv
module riu2_mapping import nird_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  pattern_pair_t pat_i,
    input  stage_ctl_t    ctl_i,
    output code_t         ni_o,
    output code_t         rd_o,
    output logic          code_valid_o,
    output logic          frame_done_o
);

    // uniform patterns map to their number of ones, all others to 9
    function automatic code_t riu2(input pattern_t p);
        int trans;
        int ones;
        trans = 0;
        ones  = 0;
        for (int k = 0; k < RING_N; k++) begin
            // circular neighbour, bit 7 wraps to bit 0
            if (p[k] != p[(k + 1) % RING_N]) begin
                trans++;
            end
            if (p[k]) begin
                ones++;
            end
        end
        if (trans <= 2) begin
            return code_t'(ones);
        end
        return code_t'(RING_N + 1);
    endfunction

    always_ff @(posedge clk_i) begin
        ni_o <= riu2(pat_i.ni);
        rd_o <= riu2(pat_i.rd);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            code_valid_o <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            code_valid_o <= ctl_i.valid;
            frame_done_o <= ctl_i.valid && ctl_i.last;
        end
    end

endmodule

//--- rtl/texture_bits.sv
module texture_bits import nird_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  window_t       win_i,
    input  stage_ctl_t    ctl_i,
    output pattern_pair_t pat_o,
    output stage_ctl_t    ctl_o
);

    localparam int CTR = WIN / 2;

    // unit steps for E, NE, N, NW, W, SW, S, SE
    // a negative row step points up, toward older rows
    localparam int DX [RING_N] = '{1, 1, 0, -1, -1, -1, 0, 1};
    localparam int DY [RING_N] = '{0, -1, -1, -1, 0, 1, 1, 1};

    pix_t          inner [RING_N];
    pix_t          outer [RING_N];
    psum_t         patch_sum;
    pattern_pair_t pat_d;

    // outer diagonals sit on the window corners, no interpolation
    always_comb begin
        for (int k = 0; k < RING_N; k++) begin
            inner[k] = win_i.row[CTR + DY[k]][CTR + DX[k]];
            outer[k] = win_i.row[CTR + 2 * DY[k]][CTR + 2 * DX[k]];
        end
    end

    always_comb begin
        patch_sum = '0;
        for (int r = 0; r < WIN; r++) begin
            for (int c = 0; c < WIN; c++) begin
                patch_sum = patch_sum + psum_t'(win_i.row[r][c]);
            end
        end
    end

    // NI tests outer >= mean as outer * 25 >= sum
    always_comb begin
        for (int k = 0; k < RING_N; k++) begin
            pat_d.rd[k] = outer[k] >= inner[k];
            pat_d.ni[k] = (psum_t'(PATCH_GAIN) * psum_t'(outer[k])) >= patch_sum;
        end
    end

    always_ff @(posedge clk_i) begin
        pat_o <= pat_d;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctl_o <= '0;
        end else begin
            ctl_o <= ctl_i;
        end
    end

endmodule

//--- rtl/window_buffer.sv
module window_buffer import nird_pkg::*; #(
    parameter int COLS = 12
) (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    pix_valid_i,
    input  pix_t    pix_i,
    output window_t win_o
);

    localparam int AW = $clog2(COLS);

    // line_mem[0] holds the previous row, line_mem[WIN-2] the oldest
    pix_t          line_mem [WIN-1][COLS];
    logic [AW-1:0] wr_col;
    win_row_t      new_col;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_col <= '0;
        end else if (pix_valid_i) begin
            if (wr_col == AW'(COLS - 1)) begin
                wr_col <= '0;
            end else begin
                wr_col <= wr_col + AW'(1);
            end
        end
    end

    // column entering the window, oldest row first
    always_comb begin
        for (int k = 0; k < WIN - 1; k++) begin
            new_col[k] = line_mem[WIN-2-k][wr_col];
        end
        new_col[WIN-1] = pix_i;
    end

    always_ff @(posedge clk_i) begin
        if (pix_valid_i) begin
            // each line moves one row down at the current column
            line_mem[0][wr_col] <= pix_i;
            for (int k = 1; k < WIN - 1; k++) begin
                line_mem[k][wr_col] <= line_mem[k-1][wr_col];
            end
            // shift left, newest column enters on the right
            for (int r = 0; r < WIN; r++) begin
                win_o.row[r] <= {new_col[r], win_o.row[r][WIN-1:1]};
            end
        end
    end

endmodule

//--- rtl/frame_fsm.sv
module frame_fsm import nird_pkg::*; #(
    parameter int COLS = 12,
    parameter int ROWS = 12
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       pix_valid_i,
    input  pos_t       col_i,
    input  pos_t       row_i,
    output stage_ctl_t ctl_o
);

    fsm_state_t state;
    fsm_state_t state_next;
    logic       win_done;
    logic       frame_end;
    logic       in_frame;

    // pixel that completes a 5x5 window
    assign win_done  = pix_valid_i && (col_i >= pos_t'(WIN - 1)) && (row_i >= pos_t'(WIN - 1));
    assign frame_end = pix_valid_i && (col_i == pos_t'(COLS - 1)) && (row_i == pos_t'(ROWS - 1));
    assign in_frame  = (state == FILL) || (state == STREAM);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (pix_valid_i) begin
                    state_next = FILL;
                end
            end
            FILL: begin
                if (frame_end) begin
                    state_next = FLUSH;
                end else if (win_done) begin
                    state_next = STREAM;
                end
            end
            STREAM: begin
                if (frame_end) begin
                    state_next = FLUSH;
                end
            end
            FLUSH: begin
                // a strobe here is already the first pixel of the next frame
                state_next = pix_valid_i ? FILL : IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // ctl_o carries the last flag while the FSM sits in FLUSH
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= IDLE;
            ctl_o <= '0;
        end else begin
            state       <= state_next;
            ctl_o.valid <= win_done && in_frame;
            ctl_o.last  <= frame_end && in_frame;
        end
    end

endmodule

//--- rtl/pixel_counter.sv
module pixel_counter import nird_pkg::*; #(
    parameter int COLS = 12,
    parameter int ROWS = 12
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic pix_valid_i,
    output pos_t col_o,
    output pos_t row_o
);

    // holds the position of the pixel on the next strobe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            col_o <= '0;
            row_o <= '0;
        end else if (pix_valid_i) begin
            if (col_o == pos_t'(COLS - 1)) begin
                col_o <= '0;
                // end of frame, start over at the top
                if (row_o == pos_t'(ROWS - 1)) begin
                    row_o <= '0;
                end else begin
                    row_o <= row_o + pos_t'(1);
                end
            end else begin
                col_o <= col_o + pos_t'(1);
            end
        end
    end

endmodule

//--- rtl/nird_pkg.sv
package nird_pkg;

    localparam int RING_N     = 8;
    localparam int WIN        = 5;
    // number of window pixels, scales an outer sample to the patch sum range
    localparam int PATCH_GAIN = 25;

    typedef logic [7:0]        pix_t;
    typedef logic [12:0]       psum_t;
    typedef logic [RING_N-1:0] pattern_t;
    typedef logic [3:0]        code_t;
    typedef logic [7:0]        pos_t;

    // one window row, index 0 is the leftmost (oldest) column
    typedef pix_t [WIN-1:0] win_row_t;

    // row 0 is the top (oldest) row of the window
    typedef struct packed {
        win_row_t [WIN-1:0] row;
    } window_t;

    typedef struct packed {
        logic valid;
        logic last;
    } stage_ctl_t;

    typedef struct packed {
        pattern_t ni;
        pattern_t rd;
    } pattern_pair_t;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        STREAM,
        FLUSH
    } fsm_state_t;

endpackage
